//--- Bender.yml
package:
  name: cache_mem

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - src/mem_timer.sv
      - src/main_mem.sv
      - cache/cache_ways.sv
      - cache/cache_ctrl.sv
      - src/cache_mem_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/cache_mem_tb.sv

//--- cache/cache_ctrl.sv
`default_nettype none

`include "cache_macros.svh"

module cache_ctrl (
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  wire logic             i_read,
    input  wire logic             i_write,
    input  cache_pkg::addr_t      i_addr,
    input  cache_pkg::word_t      i_wdata,
    output logic                  o_ready,
    output logic                  o_rvalid,
    output cache_pkg::word_t      o_rdata,
    output cache_pkg::addr_t      o_lookup_addr,
    input  wire logic             i_hit,
    input  cache_pkg::word_t      i_hit_word,
    output logic                  o_fill,
    output cache_pkg::line_u      o_fill_line,
    output logic                  o_update,
    output cache_pkg::word_t      o_update_data,
    output logic                  o_touch,
    output logic                  o_mem_rd,
    output logic                  o_mem_wr,
    output cache_pkg::addr_t      o_mem_addr,
    output cache_pkg::word_t      o_mem_wdata,
    input  wire logic             i_mem_done,
    input  cache_pkg::line_u      i_mem_rline
);
    import cache_pkg::*;

    ctrl_state_e state;
    logic        wr_pending;
    addr_t       req_addr;
    word_t       req_wdata;
    logic        req_write;
    offset_t     req_off;
    logic        accept;
    logic        wait_wr;
    logic        need_mem;
    logic        lookup_done;
    logic        refill_done;

    assign o_ready = (state == st_idle) || (state == st_idle_wp);
    assign accept  = o_ready && (i_read || i_write);
    assign req_off = req_addr[`CACHE_OFFSET_W-1:0];

    // A write-through still in flight blocks anything that needs memory
    assign wait_wr     = wr_pending && !i_mem_done;
    assign need_mem    = req_write || !i_hit;
    assign lookup_done = (state == st_lookup) && !(need_mem && wait_wr);
    assign refill_done = (state == st_refill) && i_mem_done;

    assign o_lookup_addr = req_addr;
    assign o_touch       = lookup_done && !req_write && i_hit;
    assign o_update      = lookup_done && req_write && i_hit;
    assign o_update_data = req_wdata;
    assign o_fill        = refill_done;
    assign o_fill_line   = i_mem_rline;
    assign o_mem_wdata   = req_wdata;

    // Reads fetch the aligned line, writes go to the single word
    assign o_mem_addr = req_write ? req_addr :
        {req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state      <= st_idle;
            wr_pending <= 1'b0;
            o_rvalid   <= 1'b0;
            o_mem_rd   <= 1'b0;
            o_mem_wr   <= 1'b0;
        end else begin
            o_rvalid <= 1'b0;
            o_mem_rd <= 1'b0;
            o_mem_wr <= 1'b0;
            if (wr_pending && i_mem_done) begin
                wr_pending <= 1'b0;
            end
            case (state)
                st_idle, st_idle_wp: begin
                    if (accept) begin
                        state <= st_lookup;
                    end else if (state == st_idle_wp && i_mem_done) begin
                        state <= st_idle;
                    end
                end
                st_lookup: begin
                    if (lookup_done) begin
                        if (!req_write && i_hit) begin
                            o_rvalid <= 1'b1;
                            state    <= wait_wr ? st_idle_wp : st_idle;
                        end else if (!req_write) begin
                            o_mem_rd <= 1'b1;
                            state    <= st_refill;
                        end else if (i_hit) begin
                            // CPU goes on while memory takes the word
                            o_mem_wr   <= 1'b1;
                            wr_pending <= 1'b1;
                            state      <= st_idle_wp;
                        end else begin
                            o_mem_wr <= 1'b1;
                            state    <= st_wr_miss;
                        end
                    end
                end
                st_refill: begin
                    if (i_mem_done) begin
                        o_rvalid <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_wr_miss: begin
                    if (i_mem_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
            req_write <= i_write;
        end
        if (lookup_done && !req_write) begin
            o_rdata <= i_hit_word;
        end else if (refill_done) begin
            o_rdata <= i_mem_rline.words[req_off];
        end
    end

    a_single_strobe: assert property (@(posedge clk) disable iff (i_reset)
        !(i_read && i_write));
    a_strobe_when_ready: assert property (@(posedge clk) disable iff (i_reset)
        !o_ready |-> !(i_read || i_write));
    a_rvalid_pulse: assert property (@(posedge clk) disable iff (i_reset)
        o_rvalid |=> !o_rvalid);

endmodule

`default_nettype wire

//--- cache/cache_ways.sv
`default_nettype none

`include "cache_macros.svh"

module cache_ways (
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  cache_pkg::addr_t      i_addr,
    output logic                  o_hit,
    output cache_pkg::word_t      o_hit_word,
    input  wire logic             i_fill,
    input  cache_pkg::line_u      i_fill_line,
    input  wire logic             i_update,
    input  cache_pkg::word_t      i_update_data,
    input  wire logic             i_touch
);
    import cache_pkg::*;

    localparam int NUM_SETS = 2;
    localparam int NUM_WAYS = 2;

    // Per set, one valid bit per way
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    // Per set, index of the least recently used way
    logic [NUM_SETS-1:0]               lru_q;
    tag_t                              tag_q  [NUM_SETS][NUM_WAYS];
    line_u                             data_q [NUM_SETS][NUM_WAYS];

    logic                idx;
    tag_t                tag;
    offset_t             off;
    logic [NUM_WAYS-1:0] match;
    logic                hit_way;
    logic                victim;

    assign idx = i_addr[`CACHE_IDX_BIT];
    assign tag = i_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign off = i_addr[`CACHE_OFFSET_W-1:0];

    assign match[0] = valid_q[idx][0] && (tag_q[idx][0] == tag);
    assign match[1] = valid_q[idx][1] && (tag_q[idx][1] == tag);
    assign o_hit    = |match;
    assign hit_way  = match[1];

    assign o_hit_word = data_q[idx][hit_way].words[off];

    // Empty way first, otherwise the LRU one
    assign victim = !valid_q[idx][0] ? 1'b0 :
                    !valid_q[idx][1] ? 1'b1 : lru_q[idx];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (i_fill) begin
            valid_q[idx][victim] <= 1'b1;
            lru_q[idx]           <= ~victim;
        end else if (i_update || i_touch) begin
            lru_q[idx] <= ~hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[idx][victim]       <= tag;
            data_q[idx][victim].flat <= i_fill_line.flat;
        end else if (i_update) begin
            data_q[idx][hit_way].words[off] <= i_update_data;
        end
    end

    // Refill only runs after a miss, so a tag lives in one way at most
    for (genvar s = 0; s < NUM_SETS; s++) begin : g_set_chk
        a_no_dup_tag: assert property (@(posedge clk) disable iff (i_reset)
            !(valid_q[s][0] && valid_q[s][1] && (tag_q[s][0] == tag_q[s][1])));
    end

endmodule

`default_nettype wire

//--- cache_mem.f
+incdir+common
common/cache_pkg.sv
src/mem_timer.sv
src/main_mem.sv
cache/cache_ways.sv
cache/cache_ctrl.sv
src/cache_mem_top.sv
verif/cache_mem_tb.sv

//--- common/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// CPU data word and word address
`define CACHE_WORD_W 16
`define CACHE_ADDR_W 8

// Address fields, tag on top, then set index, then word offset
`define CACHE_TAG_W 5
`define CACHE_IDX_BIT 2
`define CACHE_OFFSET_W 2

// Four words make one line
`define CACHE_WORDS_PER_LINE 4

// Main memory
`define CACHE_MEM_LATENCY 6
`define CACHE_MEM_DEPTH 256

`endif

//--- common/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    // Basic CPU-side types
    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;

    // Address fields
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // One cache line, seen whole or as words (word 0 in the low bits)
    typedef union packed {
        logic [`CACHE_WORDS_PER_LINE*`CACHE_WORD_W-1:0] flat;
        word_t [`CACHE_WORDS_PER_LINE-1:0]              words;
    } line_u;

    // Controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_wr_miss,
        st_idle_wp
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/cache_mem_top.sv
`default_nettype none

module cache_mem_top (
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  wire logic             i_read,
    input  wire logic             i_write,
    input  cache_pkg::addr_t      i_addr,
    input  cache_pkg::word_t      i_wdata,
    output logic                  o_ready,
    output logic                  o_rvalid,
    output cache_pkg::word_t      o_rdata
);
    import cache_pkg::*;

    // Controller to ways
    addr_t lookup_addr;
    logic  hit;
    word_t hit_word;
    logic  fill;
    line_u fill_line;
    logic  update;
    word_t update_data;
    logic  touch;

    // Controller to memory
    logic  mem_rd;
    logic  mem_wr;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_done;
    line_u mem_rline;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_ready       (o_ready),
        .o_rvalid      (o_rvalid),
        .o_rdata       (o_rdata),
        .o_lookup_addr (lookup_addr),
        .i_hit         (hit),
        .i_hit_word    (hit_word),
        .o_fill        (fill),
        .o_fill_line   (fill_line),
        .o_update      (update),
        .o_update_data (update_data),
        .o_touch       (touch),
        .o_mem_rd      (mem_rd),
        .o_mem_wr      (mem_wr),
        .o_mem_addr    (mem_addr),
        .o_mem_wdata   (mem_wdata),
        .i_mem_done    (mem_done),
        .i_mem_rline   (mem_rline)
    );

    cache_ways u_ways (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_addr        (lookup_addr),
        .o_hit         (hit),
        .o_hit_word    (hit_word),
        .i_fill        (fill),
        .i_fill_line   (fill_line),
        .i_update      (update),
        .i_update_data (update_data),
        .i_touch       (touch)
    );

    main_mem u_mem (
        .clk     (clk),
        .i_reset (i_reset),
        .i_rd    (mem_rd),
        .i_wr    (mem_wr),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_done  (mem_done),
        .o_rline (mem_rline)
    );

endmodule

`default_nettype wire

//--- src/main_mem.sv
`default_nettype none

`include "cache_macros.svh"

module main_mem (
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  wire logic             i_rd,
    input  wire logic             i_wr,
    input  cache_pkg::addr_t      i_addr,
    input  cache_pkg::word_t      i_wdata,
    output logic                  o_done,
    output cache_pkg::line_u      o_rline
);
    import cache_pkg::*;

    word_t mem [`CACHE_MEM_DEPTH];

    logic  start;
    logic  expired;
    logic  busy;
    logic  req_wr;
    addr_t req_addr;
    word_t req_wdata;

    assign start  = i_rd || i_wr;
    assign o_done = expired;

    mem_timer u_timer (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_start   (start),
        .o_expired (expired)
    );

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (expired) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_wr    <= i_wr;
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
        end
        if (expired && req_wr) begin
            mem[req_addr] <= req_wdata;
        end
    end

    // Gather the aligned line around the latched address
    always_comb begin
        for (int i = 0; i < `CACHE_WORDS_PER_LINE; i++) begin
            o_rline.words[i] =
                mem[{req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], `CACHE_OFFSET_W'(i)}];
        end
    end

    a_one_in_flight: assert property (@(posedge clk) disable iff (i_reset)
        start |-> !busy);

endmodule

`default_nettype wire

//--- src/mem_timer.sv
`default_nettype none

`include "cache_macros.svh"

module mem_timer (
    input  wire logic clk,
    input  wire logic i_reset,
    input  wire logic i_start,
    output logic      o_expired
);
    localparam int CNT_W = $clog2(`CACHE_MEM_LATENCY + 1);

    logic [CNT_W-1:0] count;

    // The request strobe cycle is the first cycle of latency,
    // so the counter covers the remaining ones
    always_ff @(posedge clk) begin
        if (i_reset) begin
            count     <= '0;
            o_expired <= 1'b0;
        end else begin
            o_expired <= 1'b0;
            if (count != '0) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    o_expired <= 1'b1;
                end
            end else if (i_start) begin
                count <= CNT_W'(`CACHE_MEM_LATENCY - 1);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/cache_mem_tb.sv
`default_nettype none

`include "cache_macros.svh"

module cache_mem_tb;
    import cache_pkg::*;

    localparam int CLK_PERIOD = 20;
    // Requests issued over all tests, preload included
    localparam int NUM_REQ = 2 + 32 + 9 + 9 + 5 + 64 + 300;
    localparam int WATCHDOG_CYCLES = NUM_REQ * (`CACHE_MEM_LATENCY + 4) * 2;

    logic  clk;
    logic  i_reset;
    logic  i_read;
    logic  i_write;
    addr_t i_addr;
    word_t i_wdata;
    logic  o_ready;
    logic  o_rvalid;
    word_t o_rdata;

    // Reference model state
    word_t shadow    [`CACHE_MEM_DEPTH];
    logic  ref_valid [2][2];
    tag_t  ref_tag   [2][2];
    logic  ref_lru   [2];

    // Reads still waiting for o_rvalid
    string name_q[$];
    word_t exp_word_q[$];
    logic  exp_hit_q[$];
    int    req_cycle_q[$];

    int     cycle;
    int     lat;
    int     last_lat;
    int     plain_lat;
    int     checks;
    int     errors;
    integer seed;
    integer rnd;

    cache_mem_top dut (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_read   (i_read),
        .i_write  (i_write),
        .i_addr   (i_addr),
        .i_wdata  (i_wdata),
        .o_ready  (o_ready),
        .o_rvalid (o_rvalid),
        .o_rdata  (o_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Two-way LRU cache, write-through, no allocation on a write miss
    function automatic word_t ref_access(input logic wr, input addr_t a, input word_t d,
                                         output logic hit);
        logic set;
        logic way;
        tag_t tag;
        set = a[`CACHE_IDX_BIT];
        tag = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (wr) begin
            shadow[a] = d;
        end
        if (hit) begin
            ref_lru[set] = !way;
        end else if (!wr) begin
            way = !ref_valid[set][0] ? 1'b0 : !ref_valid[set][1] ? 1'b1 : ref_lru[set];
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = tag;
            ref_lru[set]        = !way;
        end
        return shadow[a];
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            report_failure($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            report_failure($sformatf("Mismatch in %s hit: expected %b, actual %b",
                                     name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            report_failure($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Called on a falling edge, returns one falling edge after the strobe
    task automatic issue(input string name, input logic wr, input addr_t a, input word_t d);
        logic  hit;
        word_t exp;
        while (!o_ready) begin
            @(negedge clk);
        end
        exp = ref_access(wr, a, d, hit);
        if (!wr) begin
            name_q.push_back(name);
            exp_word_q.push_back(exp);
            exp_hit_q.push_back(hit);
            req_cycle_q.push_back(cycle);
        end
        i_read  = !wr;
        i_write = wr;
        i_addr  = a;
        i_wdata = d;
        @(negedge clk);
        i_read  = 1'b0;
        i_write = 1'b0;
    endtask

    task automatic wait_response();
        while (name_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic read_expect(input string name, input addr_t a, input logic exp_hit);
        issue(name, 1'b0, a, '0);
        wait_response();
        check_hit(name, exp_hit, last_lat == 2);
    endtask

    // A hit answers two edges after acceptance, anything slower is a miss
    always @(negedge clk) begin
        if (!i_reset && o_rvalid) begin
            if (name_q.size() == 0) begin
                report_failure("o_rvalid pulsed with no read outstanding");
            end else begin
                lat      = cycle - req_cycle_q[0];
                last_lat = lat;
                check_word(name_q[0], exp_word_q[0], o_rdata);
                check_hit(name_q[0], exp_hit_q[0], lat == 2);
                void'(name_q.pop_front());
                void'(exp_word_q.pop_front());
                void'(exp_hit_q.pop_front());
                void'(req_cycle_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with requests still in progress", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        i_reset   = 1'b1;
        i_read    = 1'b0;
        i_write   = 1'b0;
        i_addr    = '0;
        i_wdata   = '0;
        cycle     = 0;
        last_lat  = 0;
        plain_lat = 0;
        checks    = 0;
        errors    = 0;
        seed      = 32'h55b1_8606;
        for (int s = 0; s < 2; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (4) @(negedge clk);
        i_reset = 1'b0;

        check_flag("reset o_ready", 1'b1, o_ready);
        check_flag("reset o_rvalid", 1'b0, o_rvalid);
        issue("first_read", 1'b1, 8'hf0, 16'hbeef);
        read_expect("first_read", 8'hf0, 1'b0);

        // Four lines, only the first word of each misses
        for (int a = 'h20; a < 'h30; a++) begin
            issue("write_miss_fill", 1'b1, addr_t'(a), word_t'(16'h1000 + a * 3));
        end
        for (int a = 'h20; a < 'h30; a++) begin
            read_expect("write_miss_fill", addr_t'(a), (a % 4) != 0);
        end

        // Tags 16, 17 and 18 all in set 0
        issue("lru_evict", 1'b1, 8'h80, 16'ha0a0);
        issue("lru_evict", 1'b1, 8'h88, 16'hb0b0);
        issue("lru_evict", 1'b1, 8'h90, 16'hc0c0);
        read_expect("lru_evict", 8'h80, 1'b0);
        read_expect("lru_evict", 8'h88, 1'b0);
        read_expect("lru_evict", 8'h80, 1'b1);
        read_expect("lru_evict", 8'h90, 1'b0);
        read_expect("lru_evict", 8'h80, 1'b1);
        read_expect("lru_evict", 8'h88, 1'b0);

        // X is updated on a hit, then pushed out by Y and Z in set 1
        issue("write_through", 1'b1, 8'ha4, 16'h1111);
        read_expect("write_through", 8'ha4, 1'b0);
        issue("write_through", 1'b1, 8'ha4, 16'h2222);
        read_expect("write_through", 8'ha4, 1'b1);
        issue("write_through", 1'b1, 8'hac, 16'h3333);
        issue("write_through", 1'b1, 8'hb4, 16'h4444);
        read_expect("write_through", 8'hac, 1'b0);
        read_expect("write_through", 8'hb4, 1'b0);
        read_expect("write_through", 8'ha4, 1'b0);

        issue("write_then_miss", 1'b1, 8'hc0, 16'h5555);
        issue("write_then_miss", 1'b1, 8'hd4, 16'h6666);
        read_expect("write_then_miss", 8'hd4, 1'b0);
        plain_lat = last_lat;
        issue("write_then_miss", 1'b1, 8'hd4, 16'h7777);
        read_expect("write_then_miss", 8'hc0, 1'b0);
        checks++;
        if (last_lat <= plain_lat) begin
            report_failure($sformatf("Miss after a write hit took %0d cycles, plain miss %0d",
                                     last_lat, plain_lat));
        end

        // Every word of the random range is written before any read
        for (int a = 0; a < 64; a++) begin
            issue("random", 1'b1, addr_t'(a), word_t'({8'(a) ^ 8'h96, 8'(a)}));
        end
        for (int n = 0; n < 300; n++) begin
            rnd = $random(seed);
            issue("random", rnd[0], {2'b00, rnd[6:1]}, rnd[31:16]);
        end
        wait_response();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
